//--- tcdm_fifo_params.svh
// bus widths and default queue depth for the tcdm fifo; the data width must be a multiple of 8
`ifndef TCDM_FIFO_PARAMS_SVH
`define TCDM_FIFO_PARAMS_SVH

// address bus width in bits
`define TCDM_FIFO_AW 32

// data bus width, also sets the byte enable count
`define TCDM_FIFO_DW 32

// transaction id width
`define TCDM_FIFO_IW 8

// entries per queue, at least 2
`define TCDM_FIFO_DEPTH 8

`endif

//--- tcdm_fifo_pkg.sv
// field and word types of the tcdm fifo, all sized from the macros in the params header
package tcdm_fifo_pkg;

  `include "tcdm_fifo_params.svh"

  // single bus fields
  typedef logic [`TCDM_FIFO_AW-1:0]   addr_t;
  typedef logic [`TCDM_FIFO_DW-1:0]   data_t;
  typedef logic [`TCDM_FIFO_DW/8-1:0] be_t;  // one bit per byte lane
  typedef logic [`TCDM_FIFO_IW-1:0]   id_t;

  // request word, one request queue entry (77 bits at default widths)
  typedef struct packed {
    addr_t add;   // target address
    data_t data;  // write data, don't care on reads
    be_t   be;    // byte enables
    logic  wen;   // 1 = read, 0 = write, as on the tcdm bus
    id_t   id;    // transaction id, returned with the response
  } req_word_t;

  // response word, one response queue entry (40 bits)
  typedef struct packed {
    data_t r_data;  // read data
    id_t   r_id;    // id of the request being answered
  } rsp_word_t;

endpackage

//--- tcdm_fifo_queue.sv
// single clock circular buffer; depth must be at least 2; pop_data_o is only valid with pop_valid_o
`timescale 1ns/1ps

`include "tcdm_fifo_params.svh"

module tcdm_fifo_queue #(
  parameter type         payload_t = tcdm_fifo_pkg::data_t,
  parameter int unsigned depth     = `TCDM_FIFO_DEPTH
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     clear_i,      // synchronous flush of all entries

  input  logic     push_valid_i,
  input  payload_t push_data_i,
  output logic     push_ready_o,  // low only when all entries are taken

  output logic     pop_valid_o,
  output payload_t pop_data_o,
  input  logic     pop_ready_i,

  output logic     empty_o
);

  localparam int unsigned ptr_w = $clog2(depth);
  localparam int unsigned cnt_w = $clog2(depth + 1);  // must be able to hold depth itself

  payload_t         mem_q [depth];  // storage, no reset needed
  logic [ptr_w-1:0] wr_ptr_q;       // next slot to write
  logic [ptr_w-1:0] rd_ptr_q;       // current head
  logic [cnt_w-1:0] count_q;        // occupied entries

  logic push;
  logic pop;

  // advance with wrap at depth-1, so non power of two depths work too
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    logic [ptr_w-1:0] nxt;
    if (ptr == ptr_w'(depth - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  // handshake status straight from the counter
  assign push_ready_o = (count_q != cnt_w'(depth));
  assign pop_valid_o  = (count_q != '0);
  assign empty_o      = (count_q == '0);

  assign push = push_valid_i & push_ready_o;  // a full queue never overwrites
  assign pop  = pop_valid_o & pop_ready_i;

  assign pop_data_o = mem_q[rd_ptr_q];  // head read is combinational

  // pointers and occupancy
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // simultaneous push and pop leave the count unchanged
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // entry written at the edge of the push, seen at pop one cycle later
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

//--- tcdm_fifo_resp_capture.sv
// holds one response only; a second response while one is held and push_ready_i is low overwrites it
`timescale 1ns/1ps

module tcdm_fifo_resp_capture (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,

  input  logic                     r_valid_i,     // from the memory, ignores r_ready
  input  tcdm_fifo_pkg::rsp_word_t r_data_i,

  input  logic                     push_ready_i,  // response queue has space
  output logic                     push_valid_o,
  output tcdm_fifo_pkg::rsp_word_t push_data_o
);

  import tcdm_fifo_pkg::*;

  rsp_word_t data_q;  // last response seen on the bus
  logic      held_q;  // data_q still waits for the queue

  // live response has priority, the held one fills in otherwise
  assign push_valid_o = r_valid_i | held_q;
  assign push_data_o  = r_valid_i ? r_data_i : data_q;

  // held flag
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      held_q <= 1'b0;
    end else if (clear_i) begin
      held_q <= 1'b0;
    end else if (r_valid_i) begin
      held_q <= ~push_ready_i;  // keep it only if the queue refused it
    end else if (held_q && push_ready_i) begin
      held_q <= 1'b0;  // held entry drained into the queue
    end
  end

  // capture every response, only read back while held_q is set
  always_ff @(posedge clk_i) begin
    if (r_valid_i) begin
      data_q <= r_data_i;
    end
  end

endmodule

//--- tcdm_fifo.sv
// single clock tcdm decoupling fifo; the memory must answer at most one response per granted read
`timescale 1ns/1ps

module tcdm_fifo (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 clear_i,

  // target side, driven by the upstream initiator
  input  logic                 tgt_req_i,
  output logic                 tgt_gnt_o,
  input  tcdm_fifo_pkg::addr_t tgt_add_i,
  input  tcdm_fifo_pkg::data_t tgt_data_i,
  input  tcdm_fifo_pkg::be_t   tgt_be_i,
  input  logic                 tgt_wen_i,
  input  tcdm_fifo_pkg::id_t   tgt_id_i,
  output logic                 tgt_r_valid_o,
  input  logic                 tgt_r_ready_i,
  output tcdm_fifo_pkg::data_t tgt_r_data_o,
  output tcdm_fifo_pkg::id_t   tgt_r_id_o,

  // initiator side, towards the memory
  output logic                 init_req_o,
  input  logic                 init_gnt_i,
  output tcdm_fifo_pkg::addr_t init_add_o,
  output tcdm_fifo_pkg::data_t init_data_o,
  output tcdm_fifo_pkg::be_t   init_be_o,
  output logic                 init_wen_o,
  output tcdm_fifo_pkg::id_t   init_id_o,
  input  logic                 init_r_valid_i,
  output logic                 init_r_ready_o,
  input  tcdm_fifo_pkg::data_t init_r_data_i,
  input  tcdm_fifo_pkg::id_t   init_r_id_i,

  output logic                 empty_o  // both queues empty
);

  import tcdm_fifo_pkg::*;

  // request path
  req_word_t req_push_word;
  req_word_t req_pop_word;
  logic      req_pop_valid;
  logic      req_pop_ready;
  logic      req_empty;

  // response path
  rsp_word_t rsp_bus_word;   // as it comes from the memory
  rsp_word_t rsp_push_word;  // after the capture register
  rsp_word_t rsp_pop_word;
  logic      rsp_push_valid;
  logic      rsp_push_ready;
  logic      rsp_empty;

  logic issue;  // head may go out, there is room for its response

  // pack the incoming request
  assign req_push_word.add  = tgt_add_i;
  assign req_push_word.data = tgt_data_i;
  assign req_push_word.be   = tgt_be_i;
  assign req_push_word.wen  = tgt_wen_i;
  assign req_push_word.id   = tgt_id_i;

  tcdm_fifo_queue #(
    .payload_t ( req_word_t )
  ) u_req_queue (
    .clk_i        ( clk_i         ),
    .rst_ni       ( rst_ni        ),
    .clear_i      ( clear_i       ),
    .push_valid_i ( tgt_req_i     ),
    .push_data_i  ( req_push_word ),
    .push_ready_o ( tgt_gnt_o     ),  // gnt is plain queue space
    .pop_valid_o  ( req_pop_valid ),
    .pop_data_o   ( req_pop_word  ),
    .pop_ready_i  ( req_pop_ready ),
    .empty_o      ( req_empty     )
  );

  // no new request while a response could find the queue full
  assign issue         = req_pop_valid & rsp_push_ready;
  assign init_req_o    = issue;
  assign req_pop_ready = issue & init_gnt_i;  // pop on req and gnt

  // unpack the head onto the memory port
  assign init_add_o  = req_pop_word.add;
  assign init_data_o = req_pop_word.data;
  assign init_be_o   = req_pop_word.be;
  assign init_wen_o  = req_pop_word.wen;
  assign init_id_o   = req_pop_word.id;

  assign rsp_bus_word.r_data = init_r_data_i;
  assign rsp_bus_word.r_id   = init_r_id_i;

  // catches a response that arrives while the queue is full
  tcdm_fifo_resp_capture u_rsp_capture (
    .clk_i        ( clk_i          ),
    .rst_ni       ( rst_ni         ),
    .clear_i      ( clear_i        ),
    .r_valid_i    ( init_r_valid_i ),
    .r_data_i     ( rsp_bus_word   ),
    .push_ready_i ( rsp_push_ready ),
    .push_valid_o ( rsp_push_valid ),
    .push_data_o  ( rsp_push_word  )
  );

  tcdm_fifo_queue #(
    .payload_t ( rsp_word_t )
  ) u_rsp_queue (
    .clk_i        ( clk_i          ),
    .rst_ni       ( rst_ni         ),
    .clear_i      ( clear_i        ),
    .push_valid_i ( rsp_push_valid ),
    .push_data_i  ( rsp_push_word  ),
    .push_ready_o ( rsp_push_ready ),
    .pop_valid_o  ( tgt_r_valid_o  ),
    .pop_data_o   ( rsp_pop_word   ),
    .pop_ready_i  ( tgt_r_ready_i  ),
    .empty_o      ( rsp_empty      )
  );

  assign init_r_ready_o = rsp_push_ready;  // advisory, the capture register covers one miss

  assign tgt_r_data_o = rsp_pop_word.r_data;
  assign tgt_r_id_o   = rsp_pop_word.r_id;

  assign empty_o = req_empty & rsp_empty;

endmodule

//--- tcdm_fifo_properties.sv
// bound into tcdm_fifo; data outputs are only checked for x while their valid is high
`timescale 1ns/1ps

module tcdm_fifo_properties (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 tgt_gnt_o,
  input logic                 tgt_r_valid_o,
  input tcdm_fifo_pkg::data_t tgt_r_data_o,
  input tcdm_fifo_pkg::id_t   tgt_r_id_o,
  input logic                 init_req_o,
  input tcdm_fifo_pkg::addr_t init_add_o,
  input tcdm_fifo_pkg::data_t init_data_o,
  input tcdm_fifo_pkg::be_t   init_be_o,
  input logic                 init_wen_o,
  input tcdm_fifo_pkg::id_t   init_id_o,
  input logic                 init_r_ready_o,
  input logic                 empty_o
);

  int unsigned n_fail = 0;  // failed assertion count, read by the testbench

  // a request may only leave while its response has a place to go
  req_needs_room: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !init_r_ready_o |-> !init_req_o)
    else begin $error("init_req_o high while init_r_ready_o is low"); n_fail++; end

  // nothing to issue or return when both queues are empty
  empty_is_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    empty_o |-> (!tgt_r_valid_o && !init_req_o))
    else begin $error("traffic while empty_o is high"); n_fail++; end

  // control always known, payload known when presented
  known_outputs: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown({tgt_gnt_o, tgt_r_valid_o, init_req_o, init_r_ready_o, empty_o})
    && (!init_req_o
        || !$isunknown({init_add_o, init_data_o, init_be_o, init_wen_o, init_id_o}))
    && (!tgt_r_valid_o || !$isunknown({tgt_r_data_o, tgt_r_id_o})))
    else begin $error("unknown value on a tcdm_fifo output"); n_fail++; end

endmodule

//--- tb_tcdm_fifo.sv
// directed tests at default widths; memory model answers reads one cycle after gnt, writes get no response
`timescale 1ns/1ps

`include "tcdm_fifo_params.svh"

module tb_tcdm_fifo;

  import tcdm_fifo_pkg::*;

  localparam int    depth      = `TCDM_FIFO_DEPTH;
  localparam data_t rdata_key  = 32'h5a5a_c3c3;  // memory returns add ^ key
  localparam int    n_txn      = 24 + (depth + 1) + 12 + 2 * depth + 3;
  localparam int    max_cycles = n_txn * 20;

  logic  clk_i = 1'b0;
  logic  rst_ni, clear_i, empty_o;
  logic  tgt_req_i, tgt_gnt_o, tgt_wen_i, tgt_r_valid_o, tgt_r_ready_i;
  addr_t tgt_add_i, init_add_o;
  data_t tgt_data_i, tgt_r_data_o, init_data_o, init_r_data_i;
  be_t   tgt_be_i, init_be_o;
  id_t   tgt_id_i, tgt_r_id_o, init_id_o, init_r_id_i;
  logic  init_req_o, init_gnt_i, init_wen_o, init_r_valid_i, init_r_ready_o;

  req_word_t   exp_req[$];  // accepted at the target side, not yet seen at the initiator side
  rsp_word_t   exp_rsp[$];  // reads still owed to the target side
  int          n_req_err = 0, n_rsp_err = 0, n_bit_err = 0, n_other_err = 0;
  int          cycle_cnt = 0;
  int          gnt_mode  = 0;  // 0 random, 1 held low, 2 held high
  logic [31:0] gnt_rng   = 32'hd098_6396;
  logic [31:0] stim_rng  = ~32'hd098_6396;  // separate stream for request fields
  logic        fire;  // memory model, read granted this cycle
  addr_t       fire_add;
  id_t         fire_id;

  tcdm_fifo uut (.*);

  bind tcdm_fifo tcdm_fifo_properties u_props (.*);

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  task automatic check_req(input string name, input req_word_t act, input req_word_t exp);
    if (act !== exp) begin
      $display("error %s: got %h expected %h", name, act, exp);
      n_req_err++;
    end
  endtask

  task automatic check_rsp(input string name, input rsp_word_t act, input rsp_word_t exp);
    if (act !== exp) begin
      $display("error %s: got %h expected %h", name, act, exp);
      n_rsp_err++;
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("error %s: got %h expected %h", name, act, exp);
      n_bit_err++;
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_i);
    #1;
  endtask

  // memory side: sample at negedge, drive 1 ns after the rising edge
  always begin : memory_model
    @(negedge clk_i);
    fire     = init_req_o & init_gnt_i & init_wen_o;  // wen high is a read
    fire_add = init_add_o;
    fire_id  = init_id_o;
    @(posedge clk_i);
    #1;
    init_r_valid_i = fire;
    init_r_data_i  = fire_add ^ rdata_key;
    init_r_id_i    = fire_id;
    gnt_rng        = xorshift32(gnt_rng);
    case (gnt_mode)
      1:       init_gnt_i = 1'b0;
      2:       init_gnt_i = 1'b1;
      default: init_gnt_i = (gnt_rng[1:0] != 2'b00);  // about three grants in four
    endcase
  end

  always @(negedge clk_i) begin : initiator_monitor
    if (rst_ni && init_req_o && init_gnt_i) begin
      if (exp_req.size() == 0) begin
        $display("request with id %h left the initiator side but none was pending", init_id_o);
        n_other_err++;
      end else begin
        check_req("init_{add,data,be,wen,id}_o",
                  {init_add_o, init_data_o, init_be_o, init_wen_o, init_id_o},
                  exp_req.pop_front());
      end
    end
  end

  always @(negedge clk_i) begin : target_monitor
    if (rst_ni && tgt_r_valid_o && tgt_r_ready_i) begin
      if (exp_rsp.size() == 0) begin
        $display("response with id %h reached the target side but none was owed", tgt_r_id_o);
        n_other_err++;
      end else begin
        check_rsp("tgt_r_{data,id}_o", {tgt_r_data_o, tgt_r_id_o}, exp_rsp.pop_front());
      end
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycle_cnt++;
    if (cycle_cnt >= max_cycles) begin
      $display("timeout, the tests did not finish within %0d cycles", max_cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  // hold the request until the edge that takes it, returns the stalled cycles
  task automatic issue_req(input addr_t add, input data_t data, input be_t be, input logic wen,
                           input id_t id, output int waits);
    logic accepted;
    accepted  = 1'b0;
    waits     = 0;
    tgt_req_i = 1'b1;
    tgt_add_i = add;
    tgt_data_i = data;
    tgt_be_i  = be;
    tgt_wen_i = wen;
    tgt_id_i  = id;
    while (!accepted) begin
      @(negedge clk_i);
      accepted = tgt_gnt_o;
      if (accepted) begin
        exp_req.push_back({add, data, be, wen, id});
        if (wen) begin
          exp_rsp.push_back({data_t'(add ^ rdata_key), id});  // only reads answer
        end
      end else begin
        waits++;
      end
      @(posedge clk_i);
      #1;
    end
    tgt_req_i = 1'b0;
  endtask

  // scoreboard drained, then both queues must read empty
  task automatic wait_drain();
    while ((exp_req.size() != 0) || (exp_rsp.size() != 0)) begin
      @(posedge clk_i);
      #1;
    end
    @(negedge clk_i);
    check_bit("empty_o", empty_o, 1'b1);  // last pop was at the edge before
    @(posedge clk_i);
    #1;
  endtask

  task automatic test_order();
    logic [31:0] r;
    int          waits;
    gnt_mode = 0;
    for (int i = 0; i < 24; i++) begin
      stim_rng = xorshift32(stim_rng);
      r = stim_rng;
      issue_req(r & 32'hffff_fffc, ~r, be_t'(r[7:4]), r[0], id_t'(i), waits);
    end
    wait_drain();
  endtask

  task automatic test_gnt_stall();
    int waits;
    gnt_mode = 1;
    wait_cycles(2);
    for (int i = 0; i < depth; i++) begin
      issue_req(32'h1000 + 4 * i, 32'h0, 4'hf, 1'b1, id_t'(8'h40 + i), waits);
      check_bit("tgt_gnt_o", waits == 0, 1'b1);  // room for all depth entries
    end
    tgt_req_i = 1'b1;  // one more, must wait for a free slot
    tgt_add_i = 32'h1000 + 4 * depth;
    tgt_wen_i = 1'b1;
    tgt_id_i  = id_t'(8'h40 + depth);
    repeat (3) begin
      @(negedge clk_i);
      check_bit("tgt_gnt_o", tgt_gnt_o, 1'b0);
      @(posedge clk_i);
      #1;
    end
    gnt_mode = 0;
    issue_req(32'h1000 + 4 * depth, 32'h0, 4'hf, 1'b1, id_t'(8'h40 + depth), waits);
    wait_drain();
  endtask

  task automatic test_read_rsp();
    int waits;
    gnt_mode = 0;
    for (int i = 0; i < 12; i++) begin
      issue_req(32'h8000_0000 + 8 * i, 32'h0, 4'hf, 1'b1, id_t'(8'h80 + i), waits);
    end
    wait_drain();
  endtask

  task automatic test_rsp_stall();
    int waits;
    gnt_mode      = 2;
    tgt_r_ready_i = 1'b0;
    for (int i = 0; i < 2 * depth; i++) begin
      issue_req(32'h2000 + 4 * i, 32'h0, 4'hf, 1'b1, id_t'(8'hc0 + i), waits);
    end
    wait_cycles(4);
    @(negedge clk_i);
    check_bit("init_r_ready_o", init_r_ready_o, 1'b0);  // response queue full
    check_bit("init_req_o", init_req_o, 1'b0);
    check_bit("tgt_r_valid_o", tgt_r_valid_o, 1'b1);
    @(posedge clk_i);
    #1;
    tgt_r_ready_i = 1'b1;
    wait_drain();
    gnt_mode = 0;
  endtask

  task automatic test_empty_clear();
    int waits;
    gnt_mode = 1;
    wait_cycles(2);
    for (int i = 0; i < 3; i++) begin
      issue_req(32'h3000 + 4 * i, 32'hcafe_0000 + i, 4'h3, 1'b0, id_t'(8'he0 + i), waits);
    end
    @(negedge clk_i);
    check_bit("empty_o", empty_o, 1'b0);
    check_bit("init_req_o", init_req_o, 1'b1);
    @(posedge clk_i);
    #1;
    clear_i = 1'b1;
    wait_cycles(1);
    clear_i = 1'b0;
    exp_req.delete();  // flushed writes never reach the memory
    exp_rsp.delete();
    @(negedge clk_i);
    check_bit("empty_o", empty_o, 1'b1);
    check_bit("init_req_o", init_req_o, 1'b0);
    @(posedge clk_i);
    #1;
    gnt_mode = 0;
  endtask

  initial begin : main
    rst_ni         = 1'b0;
    clear_i        = 1'b0;
    tgt_req_i      = 1'b0;
    tgt_add_i      = '0;
    tgt_data_i     = '0;
    tgt_be_i       = '0;
    tgt_wen_i      = 1'b0;
    tgt_id_i       = '0;
    tgt_r_ready_i  = 1'b1;
    init_gnt_i     = 1'b0;
    init_r_valid_i = 1'b0;
    init_r_data_i  = '0;
    init_r_id_i    = '0;
    wait_cycles(4);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_bit("tgt_gnt_o", tgt_gnt_o, 1'b1);
    check_bit("init_r_ready_o", init_r_ready_o, 1'b1);
    check_bit("init_req_o", init_req_o, 1'b0);
    check_bit("tgt_r_valid_o", tgt_r_valid_o, 1'b0);
    check_bit("empty_o", empty_o, 1'b1);
    @(posedge clk_i);
    #1;
    test_order();
    test_gnt_stall();
    test_read_rsp();
    test_rsp_stall();
    test_empty_clear();
    $display("errors: req %0d rsp %0d flag %0d other %0d assert %0d", n_req_err, n_rsp_err,
             n_bit_err, n_other_err, uut.u_props.n_fail);
    if (n_req_err + n_rsp_err + n_bit_err + n_other_err + uut.u_props.n_fail == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- tcdm_fifo.f
+incdir+.
tcdm_fifo_pkg.sv
tcdm_fifo_queue.sv
tcdm_fifo_resp_capture.sv
tcdm_fifo.sv
tcdm_fifo_properties.sv
tb_tcdm_fifo.sv
